// File: design/rob_defines.svh
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// group geometry
`define ROB_DISP_SIZE   4
`define ROB_ENTRIES     8
`define ROB_ENTRY_W     3

// address and data widths
`define ROB_PC_W        32
`define ROB_TVAL_W      32
`define ROB_INST_BYTES  4     // pc stride between lanes

// execution side
`define ROB_DONE_PORTS  2

// rename
`define ROB_REGIDX_W    5
`define ROB_RNID_W      6

`endif

// File: design/rob_pkg.sv
`include "rob_defines.svh"

package rob_pkg;

  // exception and interrupt causes
  typedef enum logic [3:0] {
    INST_ADDR_MISALIGN = 4'd0,
    INST_ACC_FAULT     = 4'd1,
    ILLEGAL_INST       = 4'd2,
    LOAD_ACC_FAULT     = 4'd5,
    STORE_ACC_FAULT    = 4'd7,
    M_EXT_INT          = 4'd8,
    M_TIMER_INT        = 4'd9,
    M_SOFT_INT         = 4'd10,
    ECALL_M            = 4'd11,
    S_EXT_INT          = 4'd12,
    S_TIMER_INT        = 4'd13,
    S_SOFT_INT         = 4'd14
  } except_t;

  typedef logic [`ROB_DISP_SIZE-1:0]         grp_id_t;   // one bit per lane
  typedef logic [$clog2(`ROB_DISP_SIZE)-1:0] lane_t;
  typedef logic [`ROB_PC_W-1:0]              pc_t;
  typedef logic [`ROB_TVAL_W-1:0]            tval_t;

  typedef struct packed {
    logic                    wrap;
    logic [`ROB_ENTRY_W-1:0] idx;
  } cmt_id_t;

  typedef struct packed {
    logic                     valid;
    logic [`ROB_REGIDX_W-1:0] regidx;
    logic [`ROB_RNID_W-1:0]   rnid;
    logic [`ROB_RNID_W-1:0]   old_rnid;
  } wr_reg_t;

  typedef struct packed {
    logic                              valid;
    pc_t                               pc;          // lane 0 pc
    grp_id_t                           lane_valid;
    grp_id_t                           illegal;
    wr_reg_t [`ROB_DISP_SIZE-1:0]      wr_reg;
  } disp_grp_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    lane_t   lane;
    logic    except_valid;
    except_t except_type;
    tval_t   tval;
    logic    mispredict;
  } done_rpt_t;

  typedef struct packed {
    logic m_ext;
    logic m_timer;
    logic m_soft;
    logic s_ext;
    logic s_timer;
    logic s_soft;
  } int_pend_t;

  typedef struct packed {
    logic                          valid;
    pc_t                           pc;
    grp_id_t                       grp_id;
    grp_id_t                       done_grp_id;
    grp_id_t                       dead;
    grp_id_t                       except_valid;
    grp_id_t                       mispredict;
    except_t [`ROB_DISP_SIZE-1:0]  except_type;
    tval_t   [`ROB_DISP_SIZE-1:0]  tval;
    wr_reg_t [`ROB_DISP_SIZE-1:0]  wr_reg;
  } rob_entry_t;

  typedef struct packed {
    logic    except_valid;
    logic    int_valid;
    except_t cause;
    pc_t     epc;
    tval_t   tval;
    logic    flush;
  } trap_t;

  typedef struct packed {
    logic    commit;
    cmt_id_t cmt_id;
    grp_id_t grp_id;
    grp_id_t dead_id;
    trap_t   trap;
  } commit_t;

  typedef struct packed {
    logic                         commit;
    grp_id_t                      dead_id;
    wr_reg_t [`ROB_DISP_SIZE-1:0] wr_reg;
  } rnid_upd_t;

endpackage

// File: design/rob_entry_store.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_entry_store
  import rob_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  disp_grp_t  i_disp,
  input  done_rpt_t  i_done_rpt [`ROB_DONE_PORTS],
  input  logic       i_commit,
  input  logic       i_kill,
  output logic       o_disp_ready,
  output cmt_id_t    o_disp_cmt_id,
  output rob_entry_t o_head,
  output cmt_id_t    o_head_id,
  output logic       o_head_done
);

  rob_entry_t              r_entries [`ROB_ENTRIES];   // payload only
  logic [`ROB_ENTRIES-1:0] r_wrap;
  logic [`ROB_ENTRIES-1:0] r_valid;
  grp_id_t                 r_done [`ROB_ENTRIES];
  grp_id_t                 r_dead [`ROB_ENTRIES];
  cmt_id_t                 r_in_id;
  cmt_id_t                 r_out_id;
  logic [`ROB_ENTRY_W:0]   r_count;

  logic                       w_disp_fire;
  rob_entry_t                 w_new_entry;
  logic [`ROB_DONE_PORTS-1:0] w_rpt_hit;

  assign o_disp_ready  = (r_count != (`ROB_ENTRY_W+1)'(`ROB_ENTRIES));
  assign w_disp_fire   = i_disp.valid & o_disp_ready;
  assign o_disp_cmt_id = r_in_id;

  // ------------------------------
  // new entry from dispatch
  always_comb begin
    w_new_entry            = '0;
    w_new_entry.valid      = 1'b1;
    w_new_entry.pc         = i_disp.pc;
    w_new_entry.grp_id     = i_disp.lane_valid;
    w_new_entry.wr_reg     = i_disp.wr_reg;
    w_new_entry.mispredict = '0;
    for (int d = 0; d < `ROB_DISP_SIZE; d++) begin
      w_new_entry.except_valid[d] = i_disp.lane_valid[d] & i_disp.illegal[d];
      w_new_entry.except_type[d]  = ILLEGAL_INST;
      w_new_entry.tval[d]         = '0;
    end
    // a group arriving alongside a flush is born dead
    w_new_entry.dead        = i_kill ? i_disp.lane_valid : '0;
    w_new_entry.done_grp_id = i_kill ? i_disp.lane_valid : w_new_entry.except_valid;
  end

  // stale reports from an older wrap are dropped
  always_comb begin
    for (int p = 0; p < `ROB_DONE_PORTS; p++) begin
      w_rpt_hit[p] = i_done_rpt[p].valid & r_valid[i_done_rpt[p].cmt_id.idx] &
                     (r_wrap[i_done_rpt[p].cmt_id.idx] == i_done_rpt[p].cmt_id.wrap);
    end
  end

  // ------------------------------
  // payload array
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < `ROB_DONE_PORTS; p++) begin
      if (w_rpt_hit[p]) begin
        if (i_done_rpt[p].except_valid) begin
          r_entries[i_done_rpt[p].cmt_id.idx].except_valid[i_done_rpt[p].lane] <= 1'b1;
          r_entries[i_done_rpt[p].cmt_id.idx].except_type[i_done_rpt[p].lane] <=
            i_done_rpt[p].except_type;
          r_entries[i_done_rpt[p].cmt_id.idx].tval[i_done_rpt[p].lane] <= i_done_rpt[p].tval;
        end
        if (i_done_rpt[p].mispredict) begin
          r_entries[i_done_rpt[p].cmt_id.idx].mispredict[i_done_rpt[p].lane] <= 1'b1;
        end
      end
    end
    if (w_disp_fire) begin
      r_entries[r_in_id.idx] <= w_new_entry;
      r_wrap[r_in_id.idx]    <= r_in_id.wrap;
    end
  end

  // ------------------------------
  // valid, done and dead tracking
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= '0;
      r_in_id  <= '0;
      r_out_id <= '0;
      r_count  <= '0;
      for (int i = 0; i < `ROB_ENTRIES; i++) begin
        r_done[i] <= '0;
        r_dead[i] <= '0;
      end
    end else begin
      for (int p = 0; p < `ROB_DONE_PORTS; p++) begin
        if (w_rpt_hit[p]) begin
          r_done[i_done_rpt[p].cmt_id.idx][i_done_rpt[p].lane] <= 1'b1;
        end
      end
      if (i_kill) begin   // kill wins over a report in the same cycle
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
          if (r_valid[i]) begin
            r_done[i] <= r_entries[i].grp_id;
            r_dead[i] <= r_entries[i].grp_id;
          end
        end
      end
      if (i_commit) begin
        r_valid[r_out_id.idx] <= 1'b0;
        r_out_id              <= cmt_id_t'(r_out_id + 1'b1);
      end
      if (w_disp_fire) begin
        r_valid[r_in_id.idx] <= 1'b1;
        r_done[r_in_id.idx]  <= w_new_entry.done_grp_id;
        r_dead[r_in_id.idx]  <= w_new_entry.dead;
        r_in_id              <= cmt_id_t'(r_in_id + 1'b1);
      end
      case ({w_disp_fire, i_commit})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // head view with live control bits
  always_comb begin
    o_head             = r_entries[r_out_id.idx];
    o_head.valid       = r_valid[r_out_id.idx];
    o_head.done_grp_id = r_done[r_out_id.idx];
    o_head.dead        = r_dead[r_out_id.idx];
  end

  assign o_head_id   = r_out_id;
  assign o_head_done = o_head.valid & (&(o_head.done_grp_id | ~o_head.grp_id));

endmodule

// File: design/rob_trap_select.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_trap_select
  import rob_pkg::*;
(
  input  rob_entry_t i_head,
  input  int_pend_t  i_int_pend,
  output trap_t      o_trap
);

  grp_id_t w_live;
  grp_id_t w_evt;        // exception or mispredict on a live lane
  lane_t   w_lane;
  logic    w_exc;
  logic    w_int;
  except_t w_exc_cause;
  except_t w_int_cause;
  pc_t     w_lane_pc;

  assign w_live = i_head.grp_id & ~i_head.dead;
  assign w_evt  = (i_head.except_valid | i_head.mispredict) & w_live;

  // lowest lane with an event
  always_comb begin
    w_lane = '0;
    for (int d = `ROB_DISP_SIZE-1; d >= 0; d--) begin
      if (w_evt[d]) begin
        w_lane = lane_t'(d);
      end
    end
  end

  assign w_exc       = w_evt[w_lane] & i_head.except_valid[w_lane];
  assign w_exc_cause = i_head.except_type[w_lane];
  assign w_lane_pc   = i_head.pc + pc_t'(w_lane) * pc_t'(`ROB_INST_BYTES);

  // ------------------------------
  // interrupts, machine level first
  assign w_int = (|i_int_pend) & (|w_live);   // not on a fully dead group

  always_comb begin
    if (i_int_pend.m_ext)        w_int_cause = M_EXT_INT;
    else if (i_int_pend.m_timer) w_int_cause = M_TIMER_INT;
    else if (i_int_pend.m_soft)  w_int_cause = M_SOFT_INT;
    else if (i_int_pend.s_ext)   w_int_cause = S_EXT_INT;
    else if (i_int_pend.s_timer) w_int_cause = S_TIMER_INT;
    else                         w_int_cause = S_SOFT_INT;
  end

  always_comb begin
    o_trap.except_valid = w_exc & ~w_int;
    o_trap.int_valid    = w_int;
    o_trap.cause        = w_int ? w_int_cause : w_exc_cause;
    o_trap.epc          = w_int ? i_head.pc : w_lane_pc;
    if (w_int) begin
      o_trap.tval = '0;
    end else if (w_exc_cause == INST_ADDR_MISALIGN || w_exc_cause == INST_ACC_FAULT) begin
      o_trap.tval = tval_t'(w_lane_pc);    // fetch faults report the lane pc
    end else begin
      o_trap.tval = i_head.tval[w_lane];
    end
    o_trap.flush = w_exc | w_int;
  end

endmodule

// File: design/rob_squash_mask.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_squash_mask
  import rob_pkg::*;
(
  input  rob_entry_t i_head,
  output grp_id_t    o_dead_mask
);

  grp_id_t w_live;
  grp_id_t w_exc_dead;
  grp_id_t w_mis_dead;

  // lanes strictly above the lowest set bit
  function automatic grp_id_t above_lowest(grp_id_t bits);
    grp_id_t mask;
    logic    seen;
    mask = '0;
    seen = 1'b0;
    for (int d = 0; d < `ROB_DISP_SIZE; d++) begin
      mask[d] = seen;
      seen    = seen | bits[d];
    end
    return mask;
  endfunction

  assign w_live = i_head.grp_id & ~i_head.dead;

  // the offending lane itself stays live
  assign w_exc_dead = above_lowest(i_head.except_valid & w_live);
  assign w_mis_dead = above_lowest(i_head.mispredict & w_live);

  assign o_dead_mask = w_exc_dead | w_mis_dead | i_head.dead;

endmodule

// File: design/rob_commit.sv
`timescale 1ns/1ps

module rob_commit
  import rob_pkg::*;
(
  input  rob_entry_t i_head,
  input  cmt_id_t    i_head_id,
  input  logic       i_head_done,
  input  trap_t      i_trap,
  input  grp_id_t    i_dead_mask,
  output commit_t    o_commit,
  output rnid_upd_t  o_rnid_upd,
  output logic       o_kill
);

  logic    w_cmt;
  grp_id_t w_dead_id;

  assign w_cmt = i_head_done;

  assign w_dead_id = w_cmt ? (i_dead_mask & i_head.grp_id) : '0;

  // ------------------------------
  // commit record
  assign o_commit.commit  = w_cmt;
  assign o_commit.cmt_id  = i_head_id;
  assign o_commit.grp_id  = i_head.grp_id;
  assign o_commit.dead_id = w_dead_id;

  // trap flags only on a real commit
  assign o_commit.trap.except_valid = w_cmt & i_trap.except_valid;
  assign o_commit.trap.int_valid    = w_cmt & i_trap.int_valid;
  assign o_commit.trap.flush        = w_cmt & i_trap.flush;
  assign o_commit.trap.cause        = i_trap.cause;
  assign o_commit.trap.epc          = i_trap.epc;
  assign o_commit.trap.tval         = i_trap.tval;

  // ------------------------------
  // rename commit update
  assign o_rnid_upd.commit  = w_cmt;
  assign o_rnid_upd.dead_id = w_dead_id;
  assign o_rnid_upd.wr_reg  = i_head.wr_reg;   // new and old rnid per lane

  // younger entries get killed
  assign o_kill = w_cmt & i_trap.flush;

endmodule

// File: design/rob_top.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_top
  import rob_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  disp_grp_t  i_disp,
  input  done_rpt_t  i_done_rpt [`ROB_DONE_PORTS],
  input  int_pend_t  i_int_pend,
  output logic       o_disp_ready,
  output cmt_id_t    o_disp_cmt_id,
  output commit_t    o_commit,
  output rnid_upd_t  o_rnid_upd
);

  rob_entry_t w_head;
  cmt_id_t    w_head_id;
  logic       w_head_done;
  trap_t      w_trap;
  grp_id_t    w_dead_mask;
  logic       w_kill;

  rob_entry_store u_entry_store (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp        (i_disp),
    .i_done_rpt    (i_done_rpt),
    .i_commit      (o_commit.commit),
    .i_kill        (w_kill),
    .o_disp_ready  (o_disp_ready),
    .o_disp_cmt_id (o_disp_cmt_id),
    .o_head        (w_head),
    .o_head_id     (w_head_id),
    .o_head_done   (w_head_done)
  );

  rob_trap_select u_trap_select (
    .i_head     (w_head),
    .i_int_pend (i_int_pend),
    .o_trap     (w_trap)
  );

  rob_squash_mask u_squash_mask (
    .i_head      (w_head),
    .o_dead_mask (w_dead_mask)
  );

  rob_commit u_commit (
    .i_head      (w_head),
    .i_head_id   (w_head_id),
    .i_head_done (w_head_done),
    .i_trap      (w_trap),
    .i_dead_mask (w_dead_mask),
    .o_commit    (o_commit),
    .o_rnid_upd  (o_rnid_upd),
    .o_kill      (w_kill)
  );

endmodule

// File: dv/rob_props.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_props
  import rob_pkg::*;
(
  input logic                  i_clk,
  input logic                  i_reset_n,
  input rob_entry_t            i_head,
  input logic [`ROB_ENTRY_W:0] i_count,
  input commit_t               i_commit
);

  // commit only from a live head
  a_commit_head_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit.commit |-> i_head.valid)
    else $error("commit while head entry invalid");

  a_count_bound: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_count <= (`ROB_ENTRY_W+1)'(`ROB_ENTRIES))
    else $error("occupancy above buffer size");

  // dead lanes must be real lanes
  a_dead_subset: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_head.valid |-> (i_head.dead & ~i_head.grp_id) == '0)
    else $error("dead lanes outside grp_id");

endmodule

bind rob_top rob_props u_props (
  .i_clk     (i_clk),
  .i_reset_n (i_reset_n),
  .i_head    (w_head),
  .i_count   (u_entry_store.r_count),
  .i_commit  (o_commit)
);

// File: dv/rob_tb.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_tb
  import rob_pkg::*;
();

  localparam int MEM_DEPTH = 128;
  localparam int VW        = 168;   // 42 hex digits per vector line

  logic      clk = 1'b0;
  logic      reset_n;
  disp_grp_t disp;
  done_rpt_t done_rpt [`ROB_DONE_PORTS];
  int_pend_t int_pend;
  logic      disp_ready;
  cmt_id_t   disp_cmt_id;
  commit_t   cmt;
  rnid_upd_t rnid_upd;

  logic [VW-1:0]                vec_mem [MEM_DEPTH];
  logic [VW-1:0]                stim_q [$];
  logic [VW-1:0]                exp_q [$];
  wr_reg_t [`ROB_DISP_SIZE-1:0] wr_tab [16];   // dispatched rename data by commit id
  logic [`ROB_ENTRY_W:0]        next_id = '0;  // id the next accepted group gets
  int   occ = 0;                               // groups held in the buffer
  int   cycle_cnt = 0;
  int   cycle_limit = 0;
  int   err_cnt = 0;
  int   pass_cnt = 0;
  int   fail_cnt = 0;
  logic rec_bad;

  always #2 clk = ~clk;

  rob_top uut (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_disp        (disp),
    .i_done_rpt    (done_rpt),
    .i_int_pend    (int_pend),
    .o_disp_ready  (disp_ready),
    .o_disp_cmt_id (disp_cmt_id),
    .o_commit      (cmt),
    .o_rnid_upd    (rnid_upd)
  );

  // made-up rename data, unique per group pc and lane
  function automatic wr_reg_t lane_wr_reg(logic [31:0] pc, logic [3:0] lanes, int d);
    wr_reg_t r;
    r.valid    = lanes[d];
    r.regidx   = 5'(d + 1);
    r.rnid     = 6'(pc[9:4] + 6'(d));
    r.old_rnid = ~r.rnid;
    return r;
  endfunction

  function automatic done_rpt_t to_rpt(logic [55:0] f);
    done_rpt_t r;
    r.valid        = f[52];
    r.cmt_id       = cmt_id_t'(f[51:48]);
    r.lane         = f[45:44];
    r.except_valid = f[40];
    r.except_type  = except_t'(f[39:36]);
    r.mispredict   = f[32];
    r.tval         = f[31:0];
    return r;
  endfunction

  // reports go out once, a held dispatch repeats alone
  task automatic apply_line(input logic [VW-1:0] v, input logic first);
    disp.valid      = v[160];
    disp.pc         = v[159:128];
    disp.lane_valid = v[127:124];
    disp.illegal    = v[123:120];
    for (int d = 0; d < `ROB_DISP_SIZE; d++) begin
      disp.wr_reg[d] = lane_wr_reg(v[159:128], v[127:124], d);
    end
    int_pend    = int_pend_t'(v[117:112]);
    done_rpt[0] = first ? to_rpt(v[111:56]) : '0;
    done_rpt[1] = first ? to_rpt(v[55:0]) : '0;
  endtask

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
      rec_bad = 1'b1;
    end
  endtask

  // ------------------------------
  // commit checker
  task automatic check_commit();
    logic [VW-1:0] e;
    logic [3:0]    id;
    if (exp_q.size() == 0) begin
      $display("unexpected commit of id %h, no expected record left", cmt.cmt_id);
      fail_cnt++;
    end else begin
      e       = exp_q.pop_front();
      id      = e[163:160];
      rec_bad = 1'b0;
      check_field("cmt_id", 32'(cmt.cmt_id), 32'(id));
      check_field("grp_id", 32'(cmt.grp_id), 32'(e[159:156]));
      check_field("dead_id", 32'(cmt.dead_id), 32'(e[155:152]));
      check_field("except_valid", 32'(cmt.trap.except_valid), 32'(e[148]));
      check_field("int_valid", 32'(cmt.trap.int_valid), 32'(e[144]));
      check_field("flush", 32'(cmt.trap.flush), 32'(e[148] | e[144]));
      if (e[148] || e[144]) begin   // trap fields only matter on a trap
        check_field("cause", 32'(cmt.trap.cause), 32'(e[143:140]));
        check_field("epc", cmt.trap.epc, e[139:108]);
        check_field("tval", cmt.trap.tval, e[107:76]);
      end
      check_field("rnid_upd.commit", 32'(rnid_upd.commit), 32'd1);
      check_field("rnid_upd.dead_id", 32'(rnid_upd.dead_id), 32'(e[155:152]));
      for (int d = 0; d < `ROB_DISP_SIZE; d++) begin
        check_field("rnid_upd.wr_reg", 32'(rnid_upd.wr_reg[d]), 32'(wr_tab[id][d]));
      end
      if (rec_bad) fail_cnt++;
      else pass_cnt++;
      $display("commit test id %h: %s", id, rec_bad ? "mismatch" : "ok");
    end
  endtask

  always @(posedge clk) begin
    if (reset_n) begin
      cycle_cnt++;
      // ready drops only with a full buffer
      check_field("disp_ready", 32'(disp_ready), 32'(occ != `ROB_ENTRIES));
      if (disp.valid && disp_ready) begin
        check_field("disp_cmt_id", 32'(disp_cmt_id), 32'(next_id));
        wr_tab[next_id] = disp.wr_reg;
        next_id++;
        occ++;
      end
      if (cmt.commit) begin
        check_commit();
        occ--;
      end
      if (cycle_cnt > cycle_limit) begin
        $display("timeout after %0d cycles, %0d commits never seen", cycle_cnt, exp_q.size());
        $display("RESULT: FAIL");
        $finish;
      end
    end
  end

  // ------------------------------
  // stimulus
  initial begin
    int   n;
    logic first;
    logic accepted;
    reset_n     = 1'b0;
    disp        = '0;
    done_rpt[0] = '0;
    done_rpt[1] = '0;
    int_pend    = '0;
    $readmemh("dv/rob_vectors.txt", vec_mem);
    n = 0;
    while (n < MEM_DEPTH && (vec_mem[n][167:164] === 4'h1 || vec_mem[n][167:164] === 4'h2)) begin
      if (vec_mem[n][167:164] === 4'h1) stim_q.push_back(vec_mem[n]);
      else exp_q.push_back(vec_mem[n]);
      n++;
    end
    cycle_limit = n * 4 + 50;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    rec_bad = 1'b0;
    check_field("commit after reset", 32'(cmt.commit), 32'd0);
    check_field("rnid_upd.commit after reset", 32'(rnid_upd.commit), 32'd0);
    check_field("trap flags after reset",
                32'({cmt.trap.except_valid, cmt.trap.int_valid, cmt.trap.flush}), 32'd0);
    check_field("disp_ready after reset", 32'(disp_ready), 32'd1);
    foreach (stim_q[i]) begin
      first    = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        apply_line(stim_q[i], first);
        first = 1'b0;
        @(posedge clk);
        accepted = !disp.valid || disp_ready;   // full buffer holds the group
      end
    end
    @(negedge clk);
    disp        = '0;
    done_rpt[0] = '0;
    done_rpt[1] = '0;
    int_pend    = '0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (3) @(negedge clk);   // catch stray commits
    $display("commits ok %0d, commits bad %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+design
design/rob_pkg.sv
design/rob_entry_store.sv
design/rob_trap_select.sv
design/rob_squash_mask.sv
design/rob_commit.sv
design/rob_top.sv
dv/rob_props.sv
dv/rob_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the reorder buffer testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module rob_tb -Mdir obj_dir -o rob_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/rob_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" <<< "$output"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: dv/rob_vectors.txt
// stim: 1_dispvalid_pc_lanes_illegal_intpend_port0_port1, port = vld id lane exc type mis _ tval
// expect: 2_cmtid_grp_dead_exc_int_cause_epc_tval_pad
1_1_00001000_f_0_00_000000_00000000_000000_00000000
1_1_00001010_3_0_00_000000_00000000_000000_00000000
1_0_00000000_0_0_00_110000_00000000_111000_00000000
1_0_00000000_0_0_00_100000_00000000_101000_00000000
1_0_00000000_0_0_00_102000_00000000_103000_00000000
1_1_00002000_7_2_00_000000_00000000_000000_00000000
1_1_00002010_1_0_00_120000_00000000_122000_00000000
1_1_00002020_3_0_00_000000_00000000_000000_00000000
1_1_00003000_3_0_00_000000_00000000_000000_00000000
1_1_00003100_1_0_00_000000_00000000_000000_00000000
1_0_00000000_0_0_00_150000_00000000_151110_deadbeef
1_0_00000000_0_0_00_000000_00000000_000000_00000000
1_1_00003200_1_0_00_000000_00000000_000000_00000000
1_0_00000000_0_0_00_170150_12345678_000000_00000000
1_0_00000000_0_0_00_000000_00000000_000000_00000000
1_1_00004000_f_0_00_000000_00000000_000000_00000000
1_0_00000000_0_0_00_181001_00000000_180000_00000000
1_0_00000000_0_0_00_182000_00000000_183000_00000000
1_1_00004100_f_0_00_000000_00000000_000000_00000000
1_0_00000000_0_0_00_192001_00000000_191170_00000abc
1_0_00000000_0_0_00_190000_00000000_193000_00000000
1_0_00000000_0_0_00_000000_00000000_000000_00000000
1_1_00005000_1_0_00_000000_00000000_000000_00000000
1_1_00005010_1_0_00_000000_00000000_000000_00000000
1_0_00000000_0_0_00_1a0000_00000000_000000_00000000
1_0_00000000_0_0_18_000000_00000000_000000_00000000
1_1_00006000_1_0_00_000000_00000000_000000_00000000
1_1_00006010_1_0_00_000000_00000000_000000_00000000
1_1_00006020_1_0_00_000000_00000000_000000_00000000
1_1_00006030_1_0_00_000000_00000000_000000_00000000
1_1_00006040_1_0_00_000000_00000000_000000_00000000
1_1_00006050_1_0_00_000000_00000000_000000_00000000
1_1_00006060_1_0_00_000000_00000000_000000_00000000
1_1_00006070_1_0_00_000000_00000000_000000_00000000
1_1_00006080_1_0_00_1c0000_00000000_000000_00000000
1_0_00000000_0_0_00_1d0000_00000000_1e0000_00000000
1_0_00000000_0_0_00_1f0000_00000000_100000_00000000
1_0_00000000_0_0_00_110000_00000000_120000_00000000
1_0_00000000_0_0_00_130000_00000000_140000_00000000
// expected commits in order
2_0_f_0_0_0_0_00000000_00000000_000000000_0000000000
2_1_3_0_0_0_0_00000000_00000000_000000000_0000000000
2_2_7_4_1_0_2_00002004_00000000_000000000_0000000000
2_3_1_1_0_0_0_00000000_00000000_000000000_0000000000
2_4_3_3_0_0_0_00000000_00000000_000000000_0000000000
2_5_3_0_1_0_1_00003004_00003004_000000000_0000000000
2_6_1_1_0_0_0_00000000_00000000_000000000_0000000000
2_7_1_0_1_0_5_00003200_12345678_000000000_0000000000
2_8_f_c_0_0_0_00000000_00000000_000000000_0000000000
2_9_f_c_1_0_7_00004104_00000abc_000000000_0000000000
2_a_1_0_0_1_9_00005000_00000000_000000000_0000000000
2_b_1_1_0_0_0_00000000_00000000_000000000_0000000000
2_c_1_0_0_0_0_00000000_00000000_000000000_0000000000
2_d_1_0_0_0_0_00000000_00000000_000000000_0000000000
2_e_1_0_0_0_0_00000000_00000000_000000000_0000000000
2_f_1_0_0_0_0_00000000_00000000_000000000_0000000000
2_0_1_0_0_0_0_00000000_00000000_000000000_0000000000
2_1_1_0_0_0_0_00000000_00000000_000000000_0000000000
2_2_1_0_0_0_0_00000000_00000000_000000000_0000000000
2_3_1_0_0_0_0_00000000_00000000_000000000_0000000000
2_4_1_0_0_0_0_00000000_00000000_000000000_0000000000
